/* include/tile_array_settings.svh */
/*
  tile array settings
  array size and global coordinate widths shared by every block of the
  compute-tile array and its testbench
*/
`ifndef TILE_ARRAY_SETTINGS_SVH
`define TILE_ARRAY_SETTINGS_SVH

// array dimensions in tiles
`define TA_TILES_X 4
`define TA_TILES_Y 3

// global coordinate widths
`define TA_X_CORD_W 6
`define TA_Y_CORD_W 6

`endif

/* design/tile_array_pkg.sv */
/*
  tile array package
  coordinate types used by the tile array RTL and its testbench
*/
`include "tile_array_settings.svh"

package tile_array_pkg;

  // global x coordinate, one per column
  typedef logic [`TA_X_CORD_W-1:0] x_cord_t;

  // global y coordinate, incremented once per row
  typedef logic [`TA_Y_CORD_W-1:0] y_cord_t;

endpackage

/* design/coord_relay.sv */
/*
  coordinate relay
  one row stage of the reset and coordinate chain. registers the local
  reset and global coordinates arriving from the north, keeps them as
  this tile's own and hands them south with y advanced by one
*/
module coord_relay
  import tile_array_pkg::*;
(
  input  logic    clk_i
  , input  logic    arst_n_i

  // from the north neighbour
  , input  logic    rst_n_i
  , input  x_cord_t x_i
  , input  y_cord_t y_i

  // to the south neighbour
  , output logic    rst_n_o
  , output x_cord_t x_o
  , output y_cord_t y_o

  // this tile
  , output x_cord_t tile_x_o
  , output y_cord_t tile_y_o
  , output logic    tile_rst_o
);

  logic    rst_n_r;
  x_cord_t x_r;
  y_cord_t y_r;

  // local reset stays active until the chain delivers a release
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rst_n_r <= 1'b0;
    end else begin
      rst_n_r <= rst_n_i;
    end
  end

  // coordinates are plain levels
  always_ff @(posedge clk_i) begin
    x_r <= x_i;
    y_r <= y_i;
  end

  assign tile_x_o   = x_r;
  assign tile_y_o   = y_r;
  assign tile_rst_o = ~rst_n_r;

  // next row down sits one y step further
  assign rst_n_o = rst_n_r;
  assign x_o     = x_r;
  assign y_o     = y_r + y_cord_t'(1);

endmodule

/* design/barrier_node.sv */
/*
  barrier node
  per-tile part of the local sense-reversal barrier. tracks the arrive
  and release senses, forwards the gather west to east along the row and
  north to south down the last column, relays the release back toward
  the north-west. the south-east corner detects completion and toggles
  the release for the whole array
*/
`include "tile_array_settings.svh"

module barrier_node #(
  parameter bit last_col_p = 1'b0
  , parameter bit last_row_p = 1'b0
) (
  input  logic clk_i
  , input  logic arst_n_i
  , input  logic tile_rst_i

  // arrival pulse from the tile
  , input  logic arrive_i

  // row gather, west to east
  , input  logic gather_w_i
  , output logic gather_e_o

  // column gather, last column only
  , input  logic col_gather_n_i
  , output logic col_gather_s_o

  // release links
  , input  logic release_e_i
  , input  logic release_s_i
  , output logic release_w_o
  , output logic release_n_o

  // release sense of this tile
  , output logic release_o
);

  localparam bit corner_lp = last_col_p && last_row_p;

  // longest release plus gather round trip, with margin
  localparam int flush_lp   = 2 * (`TA_TILES_X + `TA_TILES_Y);
  localparam int flush_w_lp = $clog2(flush_lp + 1);

  logic arrive_sense_r;
  logic release_r;
  logic release_d;
  logic arrived;
  logic row_full;
  logic gather_e_r;
  logic col_gather_s_r;

  assign arrived  = arrive_sense_r ^ release_r;
  assign row_full = gather_w_i & arrived;

  // a pulse while already arrived is dropped
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      arrive_sense_r <= 1'b0;
    end else if (tile_rst_i) begin
      arrive_sense_r <= 1'b0;
    end else if (arrive_i && !arrived) begin
      arrive_sense_r <= ~arrive_sense_r;
    end
  end

  // gather hops, one register each
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gather_e_r     <= 1'b0;
      col_gather_s_r <= 1'b0;
    end else if (tile_rst_i) begin
      gather_e_r     <= 1'b0;
      col_gather_s_r <= 1'b0;
    end else begin
      gather_e_r     <= row_full;
      col_gather_s_r <= row_full & col_gather_n_i;
    end
  end

  if (corner_lp) begin : g_corner
    logic [flush_w_lp-1:0] flush_cnt_r;
    logic                  armed;
    logic                  fire;

    // stale highs from the previous barrier may still sit in the gather
    // registers, so wait for the pipeline to flush before re-arming
    assign armed = (flush_cnt_r == '0);
    assign fire  = armed & row_full & col_gather_n_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        flush_cnt_r <= '0;
      end else if (tile_rst_i) begin
        flush_cnt_r <= '0;
      end else if (fire) begin
        flush_cnt_r <= flush_w_lp'(flush_lp);
      end else if (!armed) begin
        flush_cnt_r <= flush_cnt_r - flush_w_lp'(1);
      end
    end

    assign release_d = release_r ^ fire;
  end else begin : g_hop
    // last column listens south, the rest listen east
    assign release_d = last_col_p ? release_s_i : release_e_i;
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      release_r <= 1'b0;
    end else if (tile_rst_i) begin
      release_r <= 1'b0;
    end else begin
      release_r <= release_d;
    end
  end

  assign gather_e_o     = gather_e_r;
  assign col_gather_s_o = last_col_p ? col_gather_s_r : 1'b0;
  assign release_w_o    = release_r;
  assign release_n_o    = release_r;
  assign release_o      = release_r;

endmodule

/* design/array_tile.sv */
/*
  array tile
  one tile of the compute array: a coordinate relay stage feeding its
  local reset to the tile's barrier node
*/
module array_tile
  import tile_array_pkg::*;
#(
  parameter bit last_col_p = 1'b0
  , parameter bit last_row_p = 1'b0
) (
  input  logic    clk_i
  , input  logic    arst_n_i

  // coordinate and reset chain
  , input  logic    rst_n_i
  , input  x_cord_t x_i
  , input  y_cord_t y_i
  , output logic    rst_n_o
  , output x_cord_t x_o
  , output y_cord_t y_o
  , output x_cord_t tile_x_o
  , output y_cord_t tile_y_o
  , output logic    tile_rst_o

  // barrier
  , input  logic    arrive_i
  , input  logic    gather_w_i
  , output logic    gather_e_o
  , input  logic    col_gather_n_i
  , output logic    col_gather_s_o
  , input  logic    release_e_i
  , input  logic    release_s_i
  , output logic    release_w_o
  , output logic    release_n_o
  , output logic    release_o
);

  logic tile_rst;

  coord_relay relay (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .rst_n_i(rst_n_i)
    , .x_i(x_i)
    , .y_i(y_i)
    , .rst_n_o(rst_n_o)
    , .x_o(x_o)
    , .y_o(y_o)
    , .tile_x_o(tile_x_o)
    , .tile_y_o(tile_y_o)
    , .tile_rst_o(tile_rst)
  );

  // barrier stays idle until this row is out of reset
  barrier_node #(
    .last_col_p(last_col_p)
    , .last_row_p(last_row_p)
  ) bar (
    .clk_i(clk_i)
    , .arst_n_i(arst_n_i)
    , .tile_rst_i(tile_rst)
    , .arrive_i(arrive_i)
    , .gather_w_i(gather_w_i)
    , .gather_e_o(gather_e_o)
    , .col_gather_n_i(col_gather_n_i)
    , .col_gather_s_o(col_gather_s_o)
    , .release_e_i(release_e_i)
    , .release_s_i(release_s_i)
    , .release_w_o(release_w_o)
    , .release_n_o(release_n_o)
    , .release_o(release_o)
  );

  assign tile_rst_o = tile_rst;

endmodule

/* design/tile_array_top.sv */
/*
  tile array top
  grid of compute tiles stitched into a mesh. coordinates and reset
  enter at the north edge and ripple south one row per cycle; the
  barrier gathers toward the south-east corner and releases back
*/
`include "tile_array_settings.svh"

module tile_array_top
  import tile_array_pkg::*;
(
  input  logic clk_i
  , input  logic arst_n_i

  // north edge, one per column
  , input  x_cord_t [`TA_TILES_X-1:0] global_x_i
  , input  y_cord_t [`TA_TILES_X-1:0] global_y_i

  // per tile
  , input  logic [`TA_TILES_Y-1:0][`TA_TILES_X-1:0] bar_arrive_i
  , output x_cord_t [`TA_TILES_Y-1:0][`TA_TILES_X-1:0] tile_x_o
  , output y_cord_t [`TA_TILES_Y-1:0][`TA_TILES_X-1:0] tile_y_o
  , output logic [`TA_TILES_Y-1:0][`TA_TILES_X-1:0] tile_rst_o
  , output logic [`TA_TILES_Y-1:0][`TA_TILES_X-1:0] bar_release_o

  // south edge, one per column
  , output x_cord_t [`TA_TILES_X-1:0] global_x_o
  , output y_cord_t [`TA_TILES_X-1:0] global_y_o
  , output logic [`TA_TILES_X-1:0] rst_n_o
);

  localparam int tiles_x_lp = `TA_TILES_X;
  localparam int tiles_y_lp = `TA_TILES_Y;

  // chain links
  logic    [tiles_y_lp-1:0][tiles_x_lp-1:0] rst_n_li, rst_n_lo;
  x_cord_t [tiles_y_lp-1:0][tiles_x_lp-1:0] x_li, x_lo;
  y_cord_t [tiles_y_lp-1:0][tiles_x_lp-1:0] y_li, y_lo;

  // barrier links
  logic [tiles_y_lp-1:0][tiles_x_lp-1:0] gather_w_li, gather_e_lo;
  logic [tiles_y_lp-1:0][tiles_x_lp-1:0] col_n_li, col_s_lo;
  logic [tiles_y_lp-1:0][tiles_x_lp-1:0] rel_e_li, rel_s_li;
  logic [tiles_y_lp-1:0][tiles_x_lp-1:0] rel_w_lo, rel_n_lo;

  for (genvar r = 0; r < tiles_y_lp; r++) begin : row
    for (genvar c = 0; c < tiles_x_lp; c++) begin : col
      array_tile #(
        .last_col_p(c == tiles_x_lp-1)
        , .last_row_p(r == tiles_y_lp-1)
      ) tile (
        .clk_i(clk_i)
        , .arst_n_i(arst_n_i)
        , .rst_n_i(rst_n_li[r][c])
        , .x_i(x_li[r][c])
        , .y_i(y_li[r][c])
        , .rst_n_o(rst_n_lo[r][c])
        , .x_o(x_lo[r][c])
        , .y_o(y_lo[r][c])
        , .tile_x_o(tile_x_o[r][c])
        , .tile_y_o(tile_y_o[r][c])
        , .tile_rst_o(tile_rst_o[r][c])
        , .arrive_i(bar_arrive_i[r][c])
        , .gather_w_i(gather_w_li[r][c])
        , .gather_e_o(gather_e_lo[r][c])
        , .col_gather_n_i(col_n_li[r][c])
        , .col_gather_s_o(col_s_lo[r][c])
        , .release_e_i(rel_e_li[r][c])
        , .release_s_i(rel_s_li[r][c])
        , .release_w_o(rel_w_lo[r][c])
        , .release_n_o(rel_n_lo[r][c])
        , .release_o(bar_release_o[r][c])
      );

      // north edge feeds the chain, reset held while arst_n_i is low
      if (r == 0) begin : north
        assign rst_n_li[r][c] = arst_n_i;
        assign x_li[r][c]     = global_x_i[c];
        assign y_li[r][c]     = global_y_i[c];
        assign col_n_li[r][c] = 1'b1;
      end else begin : from_north
        assign rst_n_li[r][c] = rst_n_lo[r-1][c];
        assign x_li[r][c]     = x_lo[r-1][c];
        assign y_li[r][c]     = y_lo[r-1][c];
        assign col_n_li[r][c] = col_s_lo[r-1][c];
      end

      if (r == tiles_y_lp-1) begin : south
        assign rst_n_o[c]     = rst_n_lo[r][c];
        assign global_x_o[c]  = x_lo[r][c];
        assign global_y_o[c]  = y_lo[r][c];
        assign rel_s_li[r][c] = 1'b0;
      end else begin : from_south
        assign rel_s_li[r][c] = rel_n_lo[r+1][c];
      end

      // row gather starts full at the west edge
      if (c == 0) begin : west
        assign gather_w_li[r][c] = 1'b1;
      end else begin : from_west
        assign gather_w_li[r][c] = gather_e_lo[r][c-1];
      end

      if (c == tiles_x_lp-1) begin : east
        assign rel_e_li[r][c] = 1'b0;
      end else begin : from_east
        assign rel_e_li[r][c] = rel_w_lo[r][c+1];
      end
    end
  end

endmodule

/* dv/tile_array_props.sv */
/*
  tile array properties
  concurrent checks on reset and release behavior of the tile array,
  bound to the top level
*/
`include "tile_array_settings.svh"

module tile_array_props (
  input  logic clk_i
  , input  logic arst_n_i
  , input  logic [`TA_TILES_Y-1:0][`TA_TILES_X-1:0] tile_rst_o
  , input  logic [`TA_TILES_Y-1:0][`TA_TILES_X-1:0] bar_release_o
  , input  logic [`TA_TILES_X-1:0] rst_n_o
);

  // release senses are cleared by the global reset
  release_low_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> (bar_release_o == '0)
  ) else $error("release sense set while array is in reset");

  // no tile may see a release while part of the array is still in reset
  no_release_in_tile_reset: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (|tile_rst_o) |-> $stable(bar_release_o)
  ) else $error("release toggled while a tile reset was active");

  // south edge reset is the last row, one stage behind the row above
  south_rst_follows: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    rst_n_o == ~$past(tile_rst_o[`TA_TILES_Y-2])
  ) else $error("south edge reset out of step with the row above");

endmodule

bind tile_array_top tile_array_props props_inst (
  .clk_i(clk_i)
  , .arst_n_i(arst_n_i)
  , .tile_rst_o(tile_rst_o)
  , .bar_release_o(bar_release_o)
  , .rst_n_o(rst_n_o)
);

/* dv/tile_array_tb.sv */
/*
  tile array testbench
  checks reset ripple, coordinates and the barrier release, driven from
  a table of tests with a watchdog and a summary line
*/
`include "tile_array_settings.svh"

module tile_array_tb
  import tile_array_pkg::*;
;
  localparam int nx = `TA_TILES_X;
  localparam int ny = `TA_TILES_Y;
  localparam int nt = nx * ny;
  localparam int bound = 2 * (nx + ny) + 4;
  localparam int n_tests = 4;
  localparam int wd_cycles = (2 * n_tests + 1) * (2 * (nx + ny) + 40);

  logic clk_i = 1'b0;
  logic arst_n_i;
  x_cord_t [nx-1:0] global_x_i;
  y_cord_t [nx-1:0] global_y_i;
  logic [ny-1:0][nx-1:0] bar_arrive_i;
  x_cord_t [ny-1:0][nx-1:0] tile_x_o;
  y_cord_t [ny-1:0][nx-1:0] tile_y_o;
  logic [ny-1:0][nx-1:0] tile_rst_o;
  logic [ny-1:0][nx-1:0] bar_release_o;
  x_cord_t [nx-1:0] global_x_o;
  y_cord_t [nx-1:0] global_y_o;
  logic [nx-1:0] rst_n_o;

  // stimulus table
  string name_t[n_tests] = '{"missing_corner", "missing_origin", "dup_pulses", "back_to_back"};
  int xbase_t[n_tests] = '{1, 20, 40, 63};
  int ybase_t[n_tests] = '{0, 33, 60, 7};
  logic [nt-1:0] mask1_t[n_tests] = '{12'h7ff, 12'hffe, 12'hfdf, 12'hfff};
  logic [nt-1:0] mask2_t[n_tests] = '{12'h800, 12'h001, 12'h020, 12'h000};
  bit dup_t[n_tests] = '{0, 1, 1, 0};
  bit b2b_t[n_tests] = '{0, 0, 0, 1};
  int exp_t[n_tests] = '{1, 1, 1, 3};

  int seed = 32'h340e;
  int errors = 0;
  int passed = 0;
  int rel_cnt[nt];
  int base[nt];
  logic [ny-1:0][nx-1:0] rel_prev;

  tile_array_top tile_array_top_inst (.*);

  always #2 clk_i = ~clk_i;

  // count release toggles per tile where the outputs are settled
  always @(negedge clk_i) begin
    for (int t = 0; t < nt; t++) begin
      if (arst_n_i && bar_release_o[t / nx][t % nx] != rel_prev[t / nx][t % nx]) begin
        rel_cnt[t] = rel_cnt[t] + 1;
      end
    end
    rel_prev = bar_release_o;
  end

  initial begin
    repeat (wd_cycles) @(posedge clk_i);
    $display("timeout: run did not finish within %0d cycles", wd_cycles);
    $display("TEST FAIL");
    $finish;
  end

  task automatic check_value(input string test, input string what, input int exp, input int act);
    assert (exp == act) else begin
      $display("error %s %s expected %0d actual %0d", test, what, exp, act);
      errors++;
    end
  endtask

  // each tile in the mask pulses once, at a random offset of up to 3 cycles
  task automatic pulse_spread(input logic [nt-1:0] mask);
    int delay[nt];
    logic [nt-1:0] m;
    for (int t = 0; t < nt; t++) begin
      delay[t] = $random(seed) & 3;
    end
    for (int k = 0; k < 4; k++) begin
      m = '0;
      for (int t = 0; t < nt; t++) begin
        m[t] = mask[t] && (delay[t] == k);
      end
      @(posedge clk_i);
      bar_arrive_i <= m;
    end
    @(posedge clk_i);
    bar_arrive_i <= '0;
  endtask

  // counts move only on the falling edge, read them at the rising one
  task automatic check_counts(input string test, input int exp);
    for (int t = 0; t < nt; t++) begin
      check_value(test, $sformatf("tile %0d releases", t), exp, rel_cnt[t] - base[t]);
    end
  endtask

  task automatic check_coords(input int ti);
    int x_mod;
    int y_mod;
    x_mod = 1 << `TA_X_CORD_W;
    y_mod = 1 << `TA_Y_CORD_W;
    @(negedge clk_i);
    for (int r = 0; r < ny; r++) begin
      for (int c = 0; c < nx; c++) begin
        check_value(name_t[ti], $sformatf("x of (%0d,%0d)", r, c),
                    (xbase_t[ti] + c) % x_mod, int'(tile_x_o[r][c]));
        check_value(name_t[ti], $sformatf("y of (%0d,%0d)", r, c),
                    (ybase_t[ti] + 2 * c + r) % y_mod, int'(tile_y_o[r][c]));
      end
    end
    // south edge carries the y of the row below the array
    for (int c = 0; c < nx; c++) begin
      check_value(name_t[ti], $sformatf("south x of column %0d", c),
                  (xbase_t[ti] + c) % x_mod, int'(global_x_o[c]));
      check_value(name_t[ti], $sformatf("south y of column %0d", c),
                  (ybase_t[ti] + 2 * c + ny) % y_mod, int'(global_y_o[c]));
    end
  endtask

  // every tile re-arrives a random gap after its own release
  task automatic run_back_to_back(input int ti);
    int gap[nt];
    int seen[nt];
    int cycles;
    bit done;
    logic [nt-1:0] m;
    for (int t = 0; t < nt; t++) begin
      gap[t] = 0;
      seen[t] = 0;
    end
    pulse_spread(mask1_t[ti]);
    cycles = 0;
    done = 0;
    while (!done && cycles < exp_t[ti] * (bound + 8)) begin
      @(posedge clk_i);
      m = '0;
      done = 1;
      for (int t = 0; t < nt; t++) begin
        if (gap[t] == 1) m[t] = 1'b1;
        if (gap[t] > 0) gap[t]--;
        if (rel_cnt[t] - base[t] > seen[t]) begin
          seen[t] = rel_cnt[t] - base[t];
          if (seen[t] < exp_t[ti]) gap[t] = 1 + ($random(seed) & 3);
        end
        if (seen[t] < exp_t[ti]) done = 0;
      end
      bar_arrive_i <= m;
      cycles++;
    end
    @(posedge clk_i);
    bar_arrive_i <= '0;
    assert (done) else begin
      $display("%s: consecutive barriers did not all complete in time", name_t[ti]);
      errors++;
    end
  endtask

  initial begin
    int err_start;
    arst_n_i = 1'b0;
    bar_arrive_i = '0;
    rel_prev = '0;
    for (int c = 0; c < nx; c++) begin
      global_x_i[c] = '0;
      global_y_i[c] = '0;
    end
    for (int t = 0; t < nt; t++) begin
      rel_cnt[t] = 0;
    end

    // reset and its row by row release
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    check_value("reset", "tile_rst_o", (1 << nt) - 1, int'(tile_rst_o));
    check_value("reset", "bar_release_o", 0, int'(bar_release_o));
    check_value("reset", "south rst_n_o", 0, int'(rst_n_o));
    @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int k = 1; k <= ny; k++) begin
      @(posedge clk_i);
      @(negedge clk_i);
      for (int r = 0; r < ny; r++) begin
        check_value("reset", $sformatf("row %0d reset at edge %0d", r, k),
                    (r >= k) ? (1 << nx) - 1 : 0, int'(tile_rst_o[r]));
      end
      check_value("reset", $sformatf("south rst_n_o at edge %0d", k),
                  (k >= ny) ? (1 << nx) - 1 : 0, int'(rst_n_o));
    end

    for (int ti = 0; ti < n_tests; ti++) begin
      err_start = errors;
      for (int t = 0; t < nt; t++) begin
        base[t] = rel_cnt[t];
      end
      @(posedge clk_i);
      for (int c = 0; c < nx; c++) begin
        global_x_i[c] <= x_cord_t'(xbase_t[ti] + c);
        global_y_i[c] <= y_cord_t'(ybase_t[ti] + 2 * c);
      end
      repeat (ny + 1) @(posedge clk_i);
      check_coords(ti);

      if (b2b_t[ti]) begin
        run_back_to_back(ti);
      end else begin
        pulse_spread(mask1_t[ti]);
        if (dup_t[ti]) pulse_spread(mask1_t[ti]);
        // one tile still missing, nothing may be released
        repeat (bound) @(posedge clk_i);
        check_counts(name_t[ti], 0);
        pulse_spread(mask2_t[ti]);
      end
      repeat (bound) @(posedge clk_i);
      check_counts(name_t[ti], exp_t[ti]);

      if (errors == err_start) begin
        passed++;
        $display("test %s passed", name_t[ti]);
      end else begin
        $display("test %s failed with %0d errors", name_t[ti], errors - err_start);
      end
    end

    $display("summary: %0d of %0d tests passed, %0d errors", passed, n_tests, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* tile_array_top.f */
+incdir+include
design/tile_array_pkg.sv
design/coord_relay.sv
design/barrier_node.sv
design/array_tile.sv
design/tile_array_top.sv
dv/tile_array_props.sv
dv/tile_array_tb.sv

/* Makefile */
# Verilator build and run for the tile array testbench

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -f tile_array_top.f --top-module tile_array_tb -o tile_array_sim

run: build
	./obj_dir/tile_array_sim | tee sim.log
	@grep -q "TEST PASS" sim.log

lint:
	verilator --lint-only --timing -f tile_array_top.f --top-module tile_array_tb

clean:
	rm -rf obj_dir sim.log
